/* synth_top.f */
common/synth_pkg.sv
synth/voice_alloc.sv
synth/voice_osc.sv
synth/voice_mixer.sv
hdl/i2s_tx.sv
hdl/synth_top.sv
verif/tb_clock.sv
verif/synth_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds synth_top_tb with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module synth_top_tb -Mdir obj_dir -f synth_top.f

# the binary exits non-zero on $fatal, so the log decides the result
./obj_dir/Vsynth_top_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* verif/synth_top_tb.sv */
// default parameters only (8 voices, 256 clk per frame); stimulus fixed by the seed
`timescale 1ns/1ps
`default_nettype none

module synth_top_tb;

    localparam int VOICES       = 8;
    localparam int BCLK_DIV     = 4;
    localparam int FRAME_CYCLES = synth_pkg::FRAME_BITS * 2 * BCLK_DIV;
    localparam int FRAME_LIMIT  = 3 * FRAME_CYCLES;   // timeout for one frame or ack

    logic               clk;
    logic               arst_n;
    logic               note_on;
    logic               note_off;
    synth_pkg::note_t   note_id;
    synth_pkg::phase_t  note_incr;
    logic               ext_sel;
    synth_pkg::sample_t ext_left;
    synth_pkg::sample_t ext_right;
    logic               ext_ack;
    logic [VOICES-1:0]  voice_free;
    logic               bclk;
    logic               lrclk;
    logic               dacdat;

    int seed = 32'h91d4;

    // reference voice table
    logic               ref_busy [VOICES];
    synth_pkg::note_t   ref_note [VOICES];
    synth_pkg::phase_t  ref_incr [VOICES];

    // received frames in arrival order
    synth_pkg::sample_t rx_left_q [$];
    synth_pkg::sample_t rx_right_q [$];
    int                 rx_count = 0;
    int                 rx_rd = 0;           // next frame the checks will read
    int                 rx_slot = 0;         // bit slot of the last bclk rise
    logic [synth_pkg::FRAME_BITS-1:0] rx_shift = '0;
    logic               prev_bclk = 1'b0;
    logic               prev_lrclk = 1'b0;
    int                 cycle = 0;
    int                 ack_total = 0;

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (10)
    ) tb_clock_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    synth_top #(
        .VOICES     (VOICES),
        .BCLK_DIV   (BCLK_DIV)
    ) synth_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .note_on    (note_on),
        .note_off   (note_off),
        .note_id    (note_id),
        .note_incr  (note_incr),
        .ext_sel    (ext_sel),
        .ext_left   (ext_left),
        .ext_right  (ext_right),
        .ext_ack    (ext_ack),
        .voice_free (voice_free),
        .bclk       (bclk),
        .lrclk      (lrclk),
        .dacdat     (dacdat)
    );

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // ====================
    // i2s receiver
    // ====================
    // lines are looked at on the falling clk, well away from their updates
    always @(negedge clk)
    begin
        if (ext_ack)
        begin
            ack_total = ack_total + 1;
        end
        if (bclk && !prev_bclk)   // bclk rising
        begin
            rx_shift = {rx_shift[synth_pkg::FRAME_BITS-2:0], dacdat};
            if (!lrclk && prev_lrclk)   // slot 0 holds the last right bit
            begin
                rx_left_q.push_back(rx_shift[synth_pkg::FRAME_BITS-1:synth_pkg::SAMPLE_W]);
                rx_right_q.push_back(rx_shift[synth_pkg::SAMPLE_W-1:0]);
                rx_count = rx_count + 1;
                rx_slot  = 0;
            end
            else
            begin
                rx_slot = rx_slot + 1;
            end
            if (rx_count != 0)   // framing known after the first fall
            begin
                // right half is slots 16..31, the frame ends after slot 31
                check_level("lrclk", (rx_slot >= synth_pkg::SAMPLE_W)
                            && (rx_slot < synth_pkg::FRAME_BITS), lrclk);
            end
            prev_lrclk = lrclk;
        end
        prev_bclk = bclk;
    end

    // ====================
    // reference model
    // ====================
    function automatic logic [VOICES-1:0] free_map();
        logic [VOICES-1:0] free;
        for (int v = 0; v < VOICES; v++)
        begin
            free[v] = !ref_busy[v];
        end
        return free;
    endfunction

    // release first, then the lowest idle voice takes the note
    function automatic logic [VOICES-1:0] apply_event(input logic on, input logic off,
                                                      input synth_pkg::note_t id,
                                                      input synth_pkg::phase_t inc);
        logic placed;
        placed = 1'b0;
        for (int v = 0; v < VOICES; v++)
        begin
            if (off && ref_busy[v] && ref_note[v] == id)
            begin
                ref_busy[v] = 1'b0;
            end
        end
        for (int v = 0; v < VOICES; v++)
        begin
            if (on && !placed && !ref_busy[v])
            begin
                ref_busy[v] = 1'b1;
                ref_note[v] = id;
                ref_incr[v] = inc;
                placed      = 1'b1;
            end
        end
        return free_map();
    endfunction

    // each held voice moves by its increment every frame
    function automatic synth_pkg::sample_t expected_step();
        synth_pkg::sample_t sum;
        sum = '0;
        for (int v = 0; v < VOICES; v++)
        begin
            if (ref_busy[v])
            begin
                sum = sum + ref_incr[v];
            end
        end
        return sum;
    endfunction

    function automatic synth_pkg::note_t pick_unheld_id();
        synth_pkg::note_t id;
        logic             held;
        id = synth_pkg::note_t'($random(seed));
        do
        begin
            held = 1'b0;
            for (int v = 0; v < VOICES; v++)
            begin
                if (ref_busy[v] && ref_note[v] == id)
                begin
                    held = 1'b1;
                end
            end
            if (held)
            begin
                id = id + 1'b1;
            end
        end
        while (held);
        return id;
    endfunction

    // ====================
    // checks and waits
    // ====================
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_free(input logic [VOICES-1:0] expected, input logic [VOICES-1:0] actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("Fail at %0t ns: voice_free expected %b, got %b",
                                $time, expected, actual));
        end
    endtask

    task automatic check_sample(input string name, input synth_pkg::sample_t expected,
                                input synth_pkg::sample_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("Fail at %0t ns: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_step(input synth_pkg::sample_t expected, input synth_pkg::sample_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("Fail at %0t ns: mix step expected %h, got %h",
                                $time, expected, actual));
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("Fail at %0t ns: %s expected %b, got %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #1;   // drive point
    endtask

    task automatic get_frame(output synth_pkg::sample_t left, output synth_pkg::sample_t right);
        int waited;
        waited = 0;
        while (rx_count <= rx_rd)
        begin
            if (waited >= FRAME_LIMIT)
            begin
                abort_run($sformatf("no I2S frame arrived within %0d cycles", FRAME_LIMIT));
            end
            advance_cycle();
            waited++;
        end
        left  = rx_left_q[rx_rd];
        right = rx_right_q[rx_rd];
        rx_rd++;
    endtask

    task automatic wait_ack();
        int waited;
        advance_cycle();   // step off the previous pulse
        waited = 1;
        while (ext_ack !== 1'b1)
        begin
            if (waited >= FRAME_LIMIT)
            begin
                abort_run($sformatf("ext_ack did not pulse within %0d cycles", FRAME_LIMIT));
            end
            advance_cycle();
            waited++;
        end
    endtask

    // one strobe cycle; voice_free must hold now and move after the next edge
    task automatic play_event(input logic on, input logic off, input synth_pkg::note_t id,
                              input synth_pkg::phase_t inc);
        logic [VOICES-1:0] expected;
        note_on   = on;
        note_off  = off;
        note_id   = id;
        note_incr = inc;
        check_free(free_map(), voice_free);
        expected = apply_event(on, off, id, inc);
        advance_cycle();
        note_on  = 1'b0;
        note_off = 1'b0;
        check_free(expected, voice_free);
    endtask

    task automatic check_mix_steady();
        synth_pkg::sample_t l0;
        synth_pkg::sample_t r0;
        synth_pkg::sample_t l1;
        synth_pkg::sample_t r1;
        rx_rd = rx_count;   // skip frames from before the change
        repeat (3) get_frame(l0, r0);
        get_frame(l0, r0);
        get_frame(l1, r1);
        check_sample("right", l0, r0);
        check_sample("right", l1, r1);
        check_step(expected_step(), l1 - l0);
    endtask

    // ====================
    // stimulus
    // ====================
    initial
    begin
        synth_pkg::sample_t exp_left_q [$];
        synth_pkg::sample_t exp_right_q [$];
        synth_pkg::sample_t left;
        synth_pkg::sample_t right;
        int                 waited;
        int                 last_ack;
        int                 acks_before;
        note_on   = 1'b0;
        note_off  = 1'b0;
        note_id   = '0;
        note_incr = '0;
        ext_sel   = 1'b0;
        ext_left  = '0;
        ext_right = '0;
        for (int v = 0; v < VOICES; v++)
        begin
            ref_busy[v] = 1'b0;
            ref_note[v] = '0;
            ref_incr[v] = '0;
        end

        waited = 0;
        while (arst_n !== 1'b1)
        begin
            if (waited >= 40)
            begin
                abort_run("reset was never released");
            end
            advance_cycle();
            waited++;
        end
        advance_cycle();

        // idle after reset
        check_free('1, voice_free);
        check_level("ext_ack", 1'b0, ext_ack);
        repeat (2)
        begin
            get_frame(left, right);
            check_sample("left", '0, left);
            check_sample("right", '0, right);
        end

        // three voices, then fill up; voice 4 repeats the note of voice 1
        repeat (3) play_event(1'b1, 1'b0, pick_unheld_id(), synth_pkg::phase_t'($random(seed)));
        check_mix_steady();
        play_event(1'b1, 1'b0, pick_unheld_id(), synth_pkg::phase_t'($random(seed)));
        play_event(1'b1, 1'b0, ref_note[1], synth_pkg::phase_t'($random(seed)));
        repeat (3) play_event(1'b1, 1'b0, pick_unheld_id(), synth_pkg::phase_t'($random(seed)));
        check_mix_steady();
        play_event(1'b1, 1'b0, pick_unheld_id(), synth_pkg::phase_t'($random(seed)));  // no room
        check_mix_steady();

        // release both copies, then an id nobody holds
        play_event(1'b0, 1'b1, ref_note[1], '0);
        check_mix_steady();
        play_event(1'b0, 1'b1, pick_unheld_id(), '0);
        check_mix_steady();

        // retrigger of voice 0 lands in voice 0 only if the release goes first
        play_event(1'b1, 1'b1, ref_note[0], synth_pkg::phase_t'($random(seed)));
        check_mix_steady();

        // ====================
        // external stream
        // ====================
        if (ack_total != 0)
        begin
            abort_run("ext_ack pulsed while the mix was playing");
        end
        ext_sel   = 1'b1;
        ext_left  = synth_pkg::sample_t'($random(seed));
        ext_right = synth_pkg::sample_t'($random(seed));
        wait_ack();
        rx_rd       = rx_count;
        last_ack    = cycle;
        acks_before = ack_total;   // this pulse is not counted yet
        exp_left_q.push_back(ext_left);
        exp_right_q.push_back(ext_right);
        ext_left  = synth_pkg::sample_t'($random(seed));
        ext_right = synth_pkg::sample_t'($random(seed));
        get_frame(left, right);    // last frame before the switch
        for (int k = 1; k < 4; k++)
        begin
            wait_ack();
            if (cycle - last_ack != FRAME_CYCLES)
            begin
                abort_run("ext_ack pulses are not one frame apart");
            end
            last_ack = cycle;
            exp_left_q.push_back(ext_left);
            exp_right_q.push_back(ext_right);
            ext_left  = synth_pkg::sample_t'($random(seed));
            ext_right = synth_pkg::sample_t'($random(seed));
        end
        if (ack_total - acks_before != 3)
        begin
            abort_run("ext_ack did not pulse exactly once per frame");
        end
        for (int k = 0; k < exp_left_q.size(); k++)
        begin
            get_frame(left, right);
            check_sample("left", exp_left_q[k], left);
            check_sample("right", exp_right_q[k], right);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
// free-running clock from time zero; reset is released 1 ns after the last counted rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;   // same offset as the stimulus
    end

endmodule

`default_nettype wire

/* hdl/synth_top.sv */
// single clock domain; notes without a free voice are lost and ext source is never stalled
`timescale 1ns/1ps
`default_nettype none

module synth_top #(
    parameter int VOICES   = 8,
    parameter int BCLK_DIV = 4
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               note_on,
    input  wire logic               note_off,
    input  wire synth_pkg::note_t   note_id,
    input  wire synth_pkg::phase_t  note_incr,
    input  wire logic               ext_sel,     // high plays the external stream
    input  wire synth_pkg::sample_t ext_left,
    input  wire synth_pkg::sample_t ext_right,
    output logic                    ext_ack,
    output logic [VOICES-1:0]       voice_free,  // status map, one bit per voice
    output logic                    bclk,
    output logic                    lrclk,
    output logic                    dacdat
);

    logic [VOICES-1:0]  voice_start;
    logic [VOICES-1:0]  voice_active;
    synth_pkg::phase_t  voice_incr;       // shared, valid with start
    logic               sample_tick;
    synth_pkg::sample_t voice_sample [VOICES];
    synth_pkg::sample_t mix;

    // ====================
    // voice allocation
    // ====================
    voice_alloc #(
        .VOICES     (VOICES)
    ) voice_alloc_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .note_on    (note_on),
        .note_off   (note_off),
        .note_id    (note_id),
        .note_incr  (note_incr),
        .voice_free (voice_free),
        .start      (voice_start),
        .active     (voice_active),
        .incr       (voice_incr)
    );

    // ====================
    // voices
    // ====================
    for (genvar v = 0; v < VOICES; v++)
    begin : g_voice
        voice_osc voice_osc_inst (
            .clk         (clk),
            .arst_n      (arst_n),
            .start       (voice_start[v]),
            .active      (voice_active[v]),
            .incr        (voice_incr),
            .sample_tick (sample_tick),
            .sample      (voice_sample[v])
        );
    end

    voice_mixer #(
        .VOICES       (VOICES)
    ) voice_mixer_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .voice_sample (voice_sample),
        .mix          (mix)
    );

    // ====================
    // i2s output
    // ====================
    i2s_tx #(
        .BCLK_DIV    (BCLK_DIV)
    ) i2s_tx_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .mix         (mix),
        .ext_sel     (ext_sel),
        .ext_left    (ext_left),
        .ext_right   (ext_right),
        .ext_ack     (ext_ack),
        .sample_tick (sample_tick),   // paces all voices
        .bclk        (bclk),
        .lrclk       (lrclk),
        .dacdat      (dacdat)
    );

endmodule

`default_nettype wire

/* hdl/i2s_tx.sv */
// standard i2s, 16-bit words in a 32-bit frame; bclk derived from clk, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module i2s_tx #(
    parameter int BCLK_DIV = 4
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire synth_pkg::sample_t mix,
    input  wire logic               ext_sel,
    input  wire synth_pkg::sample_t ext_left,
    input  wire synth_pkg::sample_t ext_right,
    output logic                    ext_ack,
    output logic                    sample_tick,
    output logic                    bclk,
    output logic                    lrclk,
    output logic                    dacdat
);

    localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
    localparam int BIT_W = $clog2(synth_pkg::FRAME_BITS);

    logic [DIV_W-1:0]                  div_cnt;
    logic                              half_tick;   // bclk toggles
    logic                              bclk_fall;
    logic [BIT_W-1:0]                  bit_cnt;     // current bit slot
    logic [BIT_W-1:0]                  bit_cnt_next;
    logic                              frame_start;
    logic [synth_pkg::FRAME_BITS-1:0]  shreg;

    // ====================
    // bit clock
    // ====================
    assign half_tick = (div_cnt == DIV_W'(BCLK_DIV - 1));
    assign bclk_fall = half_tick && bclk;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else if (half_tick)
        begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end
        else
        begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // ====================
    // frame counter
    // ====================
    assign frame_start  = bclk_fall && (bit_cnt == BIT_W'(synth_pkg::FRAME_BITS - 1));
    assign bit_cnt_next = frame_start ? '0 : bit_cnt + BIT_W'(1);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt     <= BIT_W'(synth_pkg::FRAME_BITS - 1);   // first fall opens a frame
            lrclk       <= 1'b0;
            sample_tick <= 1'b0;
            ext_ack     <= 1'b0;
        end
        else
        begin
            sample_tick <= frame_start;
            ext_ack     <= frame_start && ext_sel;   // pop strobe for the playback source
            if (bclk_fall)
            begin
                bit_cnt <= bit_cnt_next;
                lrclk   <= (bit_cnt_next >= BIT_W'(synth_pkg::SAMPLE_W));   // high = right
            end
        end
    end

    // ====================
    // serializer
    // ====================
    // dacdat trails lrclk by one slot, so slot 0 still carries the old right lsb
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            shreg  <= '0;
            dacdat <= 1'b0;
        end
        else if (bclk_fall)
        begin
            dacdat <= shreg[synth_pkg::FRAME_BITS-1];
            if (frame_start)
            begin
                if (ext_sel)
                begin
                    shreg <= {ext_left, ext_right};
                end
                else
                begin
                    shreg <= {mix, mix};   // same mix on both channels
                end
            end
            else
            begin
                shreg <= {shreg[synth_pkg::FRAME_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* synth/voice_mixer.sv */
// plain modular sum of all voices, no saturation or scaling; one cycle latency
`timescale 1ns/1ps
`default_nettype none

module voice_mixer #(
    parameter int VOICES = 8
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire synth_pkg::sample_t voice_sample [VOICES],
    output synth_pkg::sample_t      mix
);

    synth_pkg::sample_t sum;

    // adder chain over the voice loop
    always_comb
    begin
        sum = '0;
        for (int v = 0; v < VOICES; v++)
        begin
            sum = sum + voice_sample[v];   // overflow just wraps
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mix <= '0;
        end
        else
        begin
            mix <= sum;
        end
    end

endmodule

`default_nettype wire

/* synth/voice_osc.sv */
// sawtooth from a 16-bit phase accumulator; steps only on sample_tick, silent when idle
`timescale 1ns/1ps
`default_nettype none

module voice_osc (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              start,
    input  wire logic              active,
    input  wire synth_pkg::phase_t incr,
    input  wire logic              sample_tick,
    output synth_pkg::sample_t     sample
);

    synth_pkg::phase_t phase;
    synth_pkg::phase_t step;   // latched increment of the held note

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase <= '0;
        end
        else if (start)
        begin
            phase <= '0;   // restart the ramp
        end
        else if (sample_tick && active)
        begin
            phase <= phase + step;   // wraps mod 2^16
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            step <= incr;
        end
    end

    // saw is the phase itself
    assign sample = active ? phase : '0;

endmodule

`default_nettype wire

/* synth/voice_alloc.sv */
// lowest free voice wins; note-on with a full map is dropped, note-off is applied first
`timescale 1ns/1ps
`default_nettype none

module voice_alloc #(
    parameter int VOICES = 8
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   note_on,
    input  wire logic                   note_off,
    input  wire synth_pkg::note_t       note_id,
    input  wire synth_pkg::phase_t      note_incr,
    output logic [VOICES-1:0]           voice_free,
    output logic [VOICES-1:0]           start,
    output logic [VOICES-1:0]           active,
    output synth_pkg::phase_t           incr
);

    // ====================
    // voice table
    // ====================
    synth_pkg::note_t  note_tab [VOICES];  // note held by each voice

    logic [VOICES-1:0] release_hit;     // busy voices matching note_off
    logic [VOICES-1:0] free_after_off;
    logic [VOICES-1:0] pick;            // one-hot, lowest free
    logic [VOICES-1:0] start_next;

    // release side
    always_comb
    begin
        for (int v = 0; v < VOICES; v++)
        begin
            release_hit[v] = note_off && !voice_free[v] && (note_tab[v] == note_id);
        end
    end

    assign free_after_off = voice_free | release_hit;

    // isolate lowest set bit, zero when nothing is free
    assign pick = free_after_off & (~free_after_off + VOICES'(1));

    assign start_next = note_on ? pick : '0;

    // ====================
    // registered outputs
    // ====================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            voice_free <= '1;   // all voices idle
            start      <= '0;
        end
        else
        begin
            voice_free <= free_after_off & ~start_next;
            start      <= start_next;
        end
    end

    // increment lines up with start
    always_ff @(posedge clk)
    begin
        if (note_on)
        begin
            incr <= note_incr;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int v = 0; v < VOICES; v++)
        begin
            if (start_next[v])
            begin
                note_tab[v] <= note_id;
            end
        end
    end

    assign active = ~voice_free;

endmodule

`default_nettype wire

/* common/synth_pkg.sv */
// samples are unsigned 16-bit words that wrap; FRAME_BITS must stay 2 * SAMPLE_W
`default_nettype none

package synth_pkg;

    // ====================
    // widths
    // ====================
    localparam int SAMPLE_W = 16;   // one audio word
    localparam int NOTE_W   = 7;    // note number range 0..127

    // i2s frame, left word then right word
    localparam int FRAME_BITS = 2 * SAMPLE_W;

    // ====================
    // types
    // ====================
    // audio sample and mix value, no sign
    typedef logic [SAMPLE_W-1:0] sample_t;

    // phase and step; a voice puts its phase straight out as the sample
    typedef logic [SAMPLE_W-1:0] phase_t;

    typedef logic [NOTE_W-1:0] note_t;

endpackage

`default_nettype wire
